//--- logic/vga_fb_config.svh
`ifndef VGA_FB_CONFIG_SVH
`define VGA_FB_CONFIG_SVH

// horizontal raster, in pixel positions
`define VGA_FB_H_VISIBLE 16
`define VGA_FB_H_FRONT 2
`define VGA_FB_H_SYNC 3
`define VGA_FB_H_BACK 3
`define VGA_FB_H_TOTAL 24

// vertical raster, in lines
`define VGA_FB_V_VISIBLE 8
`define VGA_FB_V_FRONT 1
`define VGA_FB_V_SYNC 2
`define VGA_FB_V_BACK 1
`define VGA_FB_V_TOTAL 12

// pixel width, split evenly over red, green and blue
`define VGA_FB_PIXEL_BITS 12
// clk cycles per pixel tick
`define VGA_FB_PIXEL_DIV 2

// scan word buffer
`define VGA_FB_FIFO_DEPTH 8
// free entries needed before the producer may step
`define VGA_FB_FIFO_SLACK 3

`endif

//--- logic/vga_fb_pkg.sv
`include "vga_fb_config.svh"

package vga_fb_pkg;

  // one colour channel
  localparam int COLOR_BITS = `VGA_FB_PIXEL_BITS / 3;
  // frame buffer covers the visible area only
  localparam int FB_WORDS = `VGA_FB_H_VISIBLE * `VGA_FB_V_VISIBLE;
  localparam int FB_ADDR_BITS = $clog2(FB_WORDS);
  // coordinates span the whole raster including blanking
  localparam int COL_BITS = $clog2(`VGA_FB_H_TOTAL);
  localparam int ROW_BITS = $clog2(`VGA_FB_V_TOTAL);

  typedef logic [COLOR_BITS-1:0] color_t;

  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
  } pixel_t;

  typedef logic [FB_ADDR_BITS-1:0] fb_addr_t;
  typedef logic [COL_BITS-1:0] col_t;
  typedef logic [ROW_BITS-1:0] row_t;

  // one raster position, sync bits are electrical levels (active low)
  typedef struct packed {
    pixel_t pixel;
    logic   visible;
    logic   hsync;
    logic   vsync;
  } scan_word_t;

  typedef struct packed {
    fb_addr_t addr;
    pixel_t   data;
  } fb_wr_t;

endpackage

//--- logic/vga_sync.sv
`timescale 1ns/1ps
`include "vga_fb_config.svh"

module vga_sync (
  input  logic              clk,
  input  logic              reset,
  input  logic              step,
  output vga_fb_pkg::col_t  column,
  output vga_fb_pkg::row_t  row,
  output logic              visible,
  output logic              hsync,
  output logic              vsync
);
  import vga_fb_pkg::*;

  // sync pulse windows, first and one past last position
  localparam col_t H_SYNC_START = col_t'(`VGA_FB_H_VISIBLE + `VGA_FB_H_FRONT);
  localparam col_t H_SYNC_END = col_t'(`VGA_FB_H_VISIBLE + `VGA_FB_H_FRONT + `VGA_FB_H_SYNC);
  localparam row_t V_SYNC_START = row_t'(`VGA_FB_V_VISIBLE + `VGA_FB_V_FRONT);
  localparam row_t V_SYNC_END = row_t'(`VGA_FB_V_VISIBLE + `VGA_FB_V_FRONT + `VGA_FB_V_SYNC);
  localparam col_t H_LAST = col_t'(`VGA_FB_H_TOTAL - 1);
  localparam row_t V_LAST = row_t'(`VGA_FB_V_TOTAL - 1);
  localparam col_t H_VIS = col_t'(`VGA_FB_H_VISIBLE);
  localparam row_t V_VIS = row_t'(`VGA_FB_V_VISIBLE);

  col_t col_next;
  row_t row_next;

  // next position, wraps at end of line and end of frame
  always_comb begin
    col_next = column + 1'b1;
    row_next = row;
    if (column == H_LAST) begin
      col_next = '0;
      if (row == V_LAST) begin
        row_next = '0;
      end else begin
        row_next = row + 1'b1;
      end
    end
  end

  // levels are decoded from the next position so they line up with it
  always_ff @(posedge clk) begin
    if (reset) begin
      column  <= '0;
      row     <= '0;
      visible <= 1'b1;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
    end else if (step) begin
      column  <= col_next;
      row     <= row_next;
      visible <= (col_next < H_VIS) && (row_next < V_VIS);
      // active low inside the pulse window
      hsync   <= !((col_next >= H_SYNC_START) && (col_next < H_SYNC_END));
      vsync   <= !((row_next >= V_SYNC_START) && (row_next < V_SYNC_END));
    end
  end

  // column must never leave the line
  column_in_line: assert property (
    @(posedge clk) disable iff (reset) int'(column) < `VGA_FB_H_TOTAL
  );

endmodule

//--- logic/fb_pixel_stream.sv
`timescale 1ns/1ps
`include "vga_fb_config.svh"

module fb_pixel_stream (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    run,
  input  logic                    room,
  output vga_fb_pkg::fb_addr_t    araddr,
  output logic                    arvalid,
  input  logic                    arready,
  input  vga_fb_pkg::pixel_t      rdata,
  input  logic                    rvalid,
  output logic                    rready,
  output logic                    push,
  output vga_fb_pkg::scan_word_t  push_word
);
  import vga_fb_pkg::*;

  typedef enum logic {
    IDLE,
    READING
  } state_t;

  // raster walker, shows the position that the next step consumes
  col_t       col;
  row_t       row;
  logic       visible;
  logic       hsync;
  logic       vsync;
  logic       step;
  fb_addr_t   addr_calc;

  // stage p1, one position with its frame buffer address
  logic       p1_valid;
  scan_word_t p1_pos;
  fb_addr_t   p1_addr;

  // stage 2, either a blank push or one outstanding read
  state_t     state;
  scan_word_t hold_word;
  logic       blank_push;

  logic       read_accepted;
  logic       read_done;
  logic       stage2_free;
  logic       p1_advance;
  logic       issue_read;

  vga_sync u_vga_sync (
    .clk     (clk),
    .reset   (reset),
    .step    (step),
    .column  (col),
    .row     (row),
    .visible (visible),
    .hsync   (hsync),
    .vsync   (vsync)
  );

  // row major address, blank positions give a don't care value
  assign addr_calc = fb_addr_t'(int'(row) * `VGA_FB_H_VISIBLE + int'(col));

  assign read_accepted = arvalid && arready;
  assign read_done = (state == READING) && rvalid && rready;
  // stage 2 frees up in the same cycle its read returns
  assign stage2_free = (state == IDLE) || read_done;
  assign p1_advance = p1_valid && stage2_free;
  assign issue_read = p1_advance && p1_pos.visible;
  // step only when the fifo has room for everything in flight
  assign step = run && room && (!p1_valid || p1_advance);

  always_ff @(posedge clk) begin
    if (reset) begin
      p1_valid <= 1'b0;
    end else if (step) begin
      p1_valid <= 1'b1;
    end else if (p1_advance) begin
      p1_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      p1_pos  <= '{pixel: '0, visible: visible, hsync: hsync, vsync: vsync};
      p1_addr <= addr_calc;
    end
  end

  // idle/reading state, a new read can start as the old one returns
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else if (issue_read) begin
      state <= READING;
    end else if (read_done) begin
      state <= IDLE;
    end
  end

  // read address channel, held until accepted
  always_ff @(posedge clk) begin
    if (reset) begin
      arvalid <= 1'b0;
    end else if (issue_read) begin
      arvalid <= 1'b1;
    end else if (read_accepted) begin
      arvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_read) begin
      araddr <= p1_addr;
    end
  end

  // data channel always ready once out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      rready <= 1'b0;
    end else begin
      rready <= 1'b1;
    end
  end

  // blank positions go out one cycle after leaving p1
  always_ff @(posedge clk) begin
    if (reset) begin
      blank_push <= 1'b0;
    end else begin
      blank_push <= p1_advance && !p1_pos.visible;
    end
  end

  // sync bits of the position in stage 2
  always_ff @(posedge clk) begin
    if (p1_advance) begin
      hold_word <= p1_pos;
    end
  end

  // returned pixel joins its held sync bits
  always_comb begin
    push_word = hold_word;
    if (read_done) begin
      push_word.pixel = rdata;
    end
  end

  assign push = blank_push || read_done;

  araddr_stable: assert property (
    @(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr)
  );

  rvalid_after_accept: assert property (
    @(posedge clk) disable iff (reset)
    rvalid |-> $past(read_accepted) || $past(rvalid && !rready)
  );

endmodule

//--- logic/fb_mem.sv
`timescale 1ns/1ps

module fb_mem (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wr,
  input  vga_fb_pkg::fb_wr_t    wr_req,
  input  vga_fb_pkg::fb_addr_t  araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output vga_fb_pkg::pixel_t    rdata,
  output logic                  rvalid,
  input  logic                  rready
);
  import vga_fb_pkg::*;

  // one pixel per visible position
  pixel_t mem [FB_WORDS];

  logic read_accepted;

  // write strobe takes effect at the end of its cycle
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_req.addr] <= wr_req.data;
    end
  end

  // only one read can be pending at a time
  assign arready = !rvalid;
  assign read_accepted = arvalid && arready;

  // registered read, data lands the cycle after acceptance
  always_ff @(posedge clk) begin
    if (read_accepted) begin
      rdata <= mem[araddr];
    end
  end

  // rvalid held until the master takes the data
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (read_accepted) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

//--- logic/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 8,
  parameter int SLACK = 1
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push,
  input  T                             wr_item,
  input  logic                         pop,
  output T                             rd_item,
  output logic                         room,
  output logic [$clog2(DEPTH+1)-1:0]   count,
  output logic                         underflow
);
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_BITS-1:0] ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  localparam ptr_t LAST_PTR = ptr_t'(DEPTH - 1);
  // room means at least SLACK entries free
  localparam cnt_t ROOM_LEVEL = cnt_t'(DEPTH - SLACK);

  T     mem [DEPTH];
  ptr_t wr_ptr;
  ptr_t rd_ptr;
  logic full;
  logic empty;
  logic do_push;
  logic do_pop;

  assign full = (count == cnt_t'(DEPTH));
  assign empty = (count == '0);
  // push into a full fifo is dropped, pop from empty does nothing
  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  assign rd_item = mem[rd_ptr];
  assign room = (count <= ROOM_LEVEL);

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_item;
    end
  end

  // circular pointers, count follows net push minus pop
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      underflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
      // sticky until reset
      if (pop && empty) begin
        underflow <= 1'b1;
      end
    end
  end

  // producer slack must keep the fifo from ever filling past depth
  no_push_when_full: assert property (@(posedge clk) disable iff (reset) full |-> !push);

  no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) empty |-> !pop);

endmodule

//--- logic/vga_out.sv
`timescale 1ns/1ps
`include "vga_fb_config.svh"

module vga_out (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      run,
  input  logic [$clog2(`VGA_FB_FIFO_DEPTH+1)-1:0]   count,
  output logic                                      pop,
  input  vga_fb_pkg::scan_word_t                    head,
  output vga_fb_pkg::color_t                        red,
  output vga_fb_pkg::color_t                        grn,
  output vga_fb_pkg::color_t                        blu,
  output logic                                      hsync,
  output logic                                      vsync,
  output logic                                      pixel_valid
);
  localparam int DIV_BITS = (`VGA_FB_PIXEL_DIV > 1) ? $clog2(`VGA_FB_PIXEL_DIV) : 1;
  localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(`VGA_FB_PIXEL_DIV - 1);
  // start popping once half the fifo is filled
  localparam logic [$bits(count)-1:0] PRIME_LEVEL = $bits(count)'(`VGA_FB_FIFO_DEPTH / 2);

  logic [DIV_BITS-1:0] div_cnt;
  logic                tick;
  logic                primed;

  // free running pixel divider
  assign tick = (div_cnt == DIV_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
    end
  end

  // once primed it stays primed
  always_ff @(posedge clk) begin
    if (reset) begin
      primed <= 1'b0;
    end else if (run && (count >= PRIME_LEVEL)) begin
      primed <= 1'b1;
    end
  end

  assign pop = primed && tick;

  // outputs follow each pop by one cycle, colour blanked outside the visible area
  always_ff @(posedge clk) begin
    if (reset) begin
      red         <= '0;
      grn         <= '0;
      blu         <= '0;
      hsync       <= 1'b1;
      vsync       <= 1'b1;
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= pop;
      if (pop) begin
        red   <= head.visible ? head.pixel.red : '0;
        grn   <= head.visible ? head.pixel.grn : '0;
        blu   <= head.visible ? head.pixel.blu : '0;
        hsync <= head.hsync;
        vsync <= head.vsync;
      end
    end
  end

endmodule

//--- logic/vga_fb_top.sv
`timescale 1ns/1ps
`include "vga_fb_config.svh"

module vga_fb_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic                fb_wr,
  input  vga_fb_pkg::fb_wr_t  fb_wr_req,
  output vga_fb_pkg::color_t  red,
  output vga_fb_pkg::color_t  grn,
  output vga_fb_pkg::color_t  blu,
  output logic                hsync,
  output logic                vsync,
  output logic                pixel_valid,
  output logic                underflow
);
  import vga_fb_pkg::*;

  // frame buffer read channel
  fb_addr_t   araddr;
  logic       arvalid;
  logic       arready;
  pixel_t     rdata;
  logic       rvalid;
  logic       rready;

  // scan word stream into and out of the fifo
  logic       push;
  scan_word_t push_word;
  logic       pop;
  scan_word_t head;
  logic       room;
  logic [$clog2(`VGA_FB_FIFO_DEPTH+1)-1:0] fifo_count;

  fb_pixel_stream u_pixel_stream (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .room      (room),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .rready    (rready),
    .push      (push),
    .push_word (push_word)
  );

  fb_mem u_fb_mem (
    .clk     (clk),
    .reset   (reset),
    .wr      (fb_wr),
    .wr_req  (fb_wr_req),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  stream_fifo #(
    .T     (scan_word_t),
    .DEPTH (`VGA_FB_FIFO_DEPTH),
    .SLACK (`VGA_FB_FIFO_SLACK)
  ) u_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .wr_item   (push_word),
    .pop       (pop),
    .rd_item   (head),
    .room      (room),
    .count     (fifo_count),
    .underflow (underflow)
  );

  vga_out u_vga_out (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .count       (fifo_count),
    .pop         (pop),
    .head        (head),
    .red         (red),
    .grn         (grn),
    .blu         (blu),
    .hsync       (hsync),
    .vsync       (vsync),
    .pixel_valid (pixel_valid)
  );

endmodule

//--- verif/vga_fb_tb.sv
`timescale 1ns/1ps
`include "vga_fb_config.svh"

module vga_fb_tb;
  import vga_fb_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 8;
  localparam int POSITIONS = `VGA_FB_H_TOTAL * `VGA_FB_V_TOTAL;
  // four frames of pixel ticks with a factor of two for margin
  localparam int WATCHDOG_CYCLES = 4 * POSITIONS * `VGA_FB_PIXEL_DIV * 2;

  // test ids
  localparam int RESET_STATE = 0;
  localparam int SYNC_TIMING = 1;
  localparam int PIXEL_DATA = 2;
  localparam int BLANKING = 3;
  localparam int FRAME_UPDATE = 4;
  localparam int NO_UNDERFLOW = 5;
  localparam int NUM_TESTS = 6;

  logic   clk;
  logic   reset;
  logic   run;
  logic   fb_wr;
  fb_wr_t fb_wr_req;
  color_t red;
  color_t grn;
  color_t blu;
  logic   hsync;
  logic   vsync;
  logic   pixel_valid;
  logic   underflow;

  // reference copy of the frame buffer
  pixel_t      shadow [FB_WORDS];
  logic [31:0] lfsr = 32'h6bbb;

  // position model that advances on every pixel_valid
  int     model_col = 0;
  int     model_row = 0;
  int     model_frame = 0;
  int     since_pv = 0;
  logic   started = 1'b0;
  logic   reset_q = 1'b0;
  logic   rewrite_go = 1'b0;
  logic   run_done = 1'b0;
  pixel_t exp_pix;
  pixel_t act_pix;

  int checks [NUM_TESTS];
  int fails [NUM_TESTS];
  int total_checks = 0;
  int total_fail = 0;

  vga_fb_top u_vga_fb_top (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .fb_wr       (fb_wr),
    .fb_wr_req   (fb_wr_req),
    .red         (red),
    .grn         (grn),
    .blu         (blu),
    .hsync       (hsync),
    .vsync       (vsync),
    .pixel_valid (pixel_valid),
    .underflow   (underflow)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic string test_name(input int id);
    case (id)
      RESET_STATE:  test_name = "reset_state";
      SYNC_TIMING:  test_name = "sync_timing";
      PIXEL_DATA:   test_name = "pixel_data";
      BLANKING:     test_name = "blanking";
      FRAME_UPDATE: test_name = "frame_update";
      default:      test_name = "no_underflow";
    endcase
  endfunction

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // sync pulse windows straight from the raster timing
  function automatic logic expected_hsync(input int c);
    int start;
    start = `VGA_FB_H_VISIBLE + `VGA_FB_H_FRONT;
    expected_hsync = !((c >= start) && (c < start + `VGA_FB_H_SYNC));
  endfunction

  function automatic logic expected_vsync(input int r);
    int start;
    start = `VGA_FB_V_VISIBLE + `VGA_FB_V_FRONT;
    expected_vsync = !((r >= start) && (r < start + `VGA_FB_V_SYNC));
  endfunction

  task automatic mismatch(input int id, input logic [31:0] expected, input logic [31:0] actual);
    fails[id]++;
    $display("[FAIL] %s expected 'h%0h actual 'h%0h at col %0d row %0d frame %0d",
             test_name(id), expected, actual, model_col, model_row, model_frame);
  endtask

  // one lfsr step per pixel bit
  task automatic random_pixel(output pixel_t p);
    logic [`VGA_FB_PIXEL_BITS-1:0] bits;
    bits = '0;
    for (int i = 0; i < `VGA_FB_PIXEL_BITS; i++) begin
      bits = {bits[`VGA_FB_PIXEL_BITS-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    p = bits;
  endtask

  // one write per clock and the shadow tracks every write
  task automatic fill_frame();
    pixel_t p;
    for (int a = 0; a < FB_WORDS; a++) begin
      random_pixel(p);
      @(posedge clk);
      fb_wr     <= 1'b1;
      fb_wr_req <= '{addr: fb_addr_t'(a), data: p};
      shadow[a] = p;
    end
    @(posedge clk);
    fb_wr <= 1'b0;
  endtask

  // stimulus
  initial begin
    reset     = 1'b1;
    run       = 1'b0;
    fb_wr     = 1'b0;
    fb_wr_req = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    fill_frame();
    @(posedge clk);
    run <= 1'b1;
    // new picture while frame 1 is in its sync rows
    wait (rewrite_go);
    fill_frame();
  end

  // reset values are checked on every edge that follows one with reset high
  always @(posedge clk) begin
    reset_q <= reset;
    if (reset_q) begin
      checks[RESET_STATE]++;
      assert ({hsync, vsync, red, grn, blu, pixel_valid, underflow} == 16'hc000)
        else mismatch(RESET_STATE, 32'hc000,
                      32'({hsync, vsync, red, grn, blu, pixel_valid, underflow}));
    end
  end

  // output positions against the raster model
  always @(posedge clk) begin
    if (!reset && !run_done && pixel_valid) begin
      checks[SYNC_TIMING]++;
      assert ({hsync, vsync} == {expected_hsync(model_col), expected_vsync(model_row)})
        else mismatch(SYNC_TIMING,
                      32'({expected_hsync(model_col), expected_vsync(model_row)}),
                      32'({hsync, vsync}));
      act_pix = '{red: red, grn: grn, blu: blu};
      if (model_col < `VGA_FB_H_VISIBLE && model_row < `VGA_FB_V_VISIBLE) begin
        exp_pix = shadow[model_row * `VGA_FB_H_VISIBLE + model_col];
        // frames 0 and 1 show the first fill and frame 2 the rewrite
        if (model_frame < 2) begin
          checks[PIXEL_DATA]++;
          assert (act_pix == exp_pix)
            else mismatch(PIXEL_DATA, 32'(exp_pix), 32'(act_pix));
        end else begin
          checks[FRAME_UPDATE]++;
          assert (act_pix == exp_pix)
            else mismatch(FRAME_UPDATE, 32'(exp_pix), 32'(act_pix));
        end
      end else begin
        checks[BLANKING]++;
        assert (act_pix == '0)
          else mismatch(BLANKING, 32'h0, 32'(act_pix));
      end
      // start of the vsync rows in frame 1
      if (model_frame == 1 && model_col == 0 &&
          model_row == `VGA_FB_V_VISIBLE + `VGA_FB_V_FRONT) begin
        rewrite_go = 1'b1;
      end
      if (model_col == `VGA_FB_H_TOTAL - 1) begin
        model_col = 0;
        if (model_row == `VGA_FB_V_TOTAL - 1) begin
          model_row = 0;
          model_frame++;
        end else begin
          model_row++;
        end
      end else begin
        model_col++;
      end
      if (model_frame == 3) begin
        run_done <= 1'b1;
      end
    end
  end

  // steady pixel rate and no fifo starvation
  always @(posedge clk) begin
    if (!reset && !run_done) begin
      checks[NO_UNDERFLOW]++;
      assert (!underflow)
        else mismatch(NO_UNDERFLOW, 32'h0, 32'(underflow));
      if (started) begin
        if (pixel_valid) begin
          assert (since_pv == `VGA_FB_PIXEL_DIV)
            else mismatch(NO_UNDERFLOW, `VGA_FB_PIXEL_DIV, since_pv);
          since_pv = 1;
        end else begin
          // reported once on the first missing tick
          assert (since_pv != `VGA_FB_PIXEL_DIV) else begin
            fails[NO_UNDERFLOW]++;
            $display("pixel_valid missed its tick at col %0d row %0d frame %0d",
                     model_col, model_row, model_frame);
          end
          since_pv++;
        end
      end else if (pixel_valid) begin
        started  = 1'b1;
        since_pv = 1;
      end
    end
  end

  task automatic report_results();
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (checks[i] == 0) begin
        fails[i]++;
        $display("%s never reached a check", test_name(i));
      end
      $display("%-13s checks %0d failures %0d", test_name(i), checks[i], fails[i]);
      total_checks += checks[i];
      total_fail += fails[i];
    end
    $display("tests %0d, checks %0d, failures %0d", NUM_TESTS, total_checks, total_fail);
  endtask

  initial begin
    wait (run_done);
    @(posedge clk);
    report_results();
    if (total_fail == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before three frames were shown",
             WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- vga_fb.f
+incdir+logic
logic/vga_fb_pkg.sv
logic/vga_sync.sv
logic/fb_pixel_stream.sv
logic/fb_mem.sv
logic/stream_fifo.sv
logic/vga_out.sv
logic/vga_fb_top.sv
verif/vga_fb_tb.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = vga_fb_tb
FILELIST   = vga_fb.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
